// File: files.f
rtl/iomem_pkg.sv
rtl/iomem_decode.sv
rtl/gpio_port.sv
rtl/i2s_tx.sv
rtl/audio_engine.sv
rtl/io_subsystem.sv
tb/tb_clock.sv
tb/tb_io_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the io_subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module tb_io_subsystem -o sim_tb; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "=== PASS ==="; then
	exit 0
fi

echo "Pass message not found"
exit 1

// File: tb/tb_io_subsystem.sv
// Directed tests for the iomem peripherals; single master, bus driven on falling clk, seed 12
`default_nettype none

module tb_io_subsystem import iomem_pkg::*; ();

	localparam logic [31:0] GPIO_ADDR     = {IOMEM_PAGE, 8'h00, GPIO_BLOCK, 12'h000};
	localparam logic [31:0] AUDIO_CTRL    = {IOMEM_PAGE, 8'h00, AUDIO_BLOCK, 12'h000};
	localparam logic [31:0] AUDIO_SAMPLE  = AUDIO_CTRL + 32'h4;
	localparam logic [31:0] AUDIO_STATUS  = AUDIO_CTRL + 32'h8;
	localparam logic [31:0] UNMAPPED_ADDR = 32'h0300_3000;
	// 32 bits of 4 clk each
	localparam int FRAME_CLKS = 128;
	// About a dozen frames plus bus traffic, wide margin
	localparam int WATCHDOG_TIME = 400000;

	logic clk;
	logic rst_n;
	iomem_req_t bus_req;
	iomem_rsp_t bus_rsp;
	logic [7:0] leds;
	logic i2s_sck;
	logic i2s_ws;
	logic i2s_sd;
	integer seed;
	int errors;
	int tests_passed;
	int tests_failed;
	logic [7:0] led_expect;
	logic [31:0] sample_q[$];
	logic [31:0] frames_q[$];

	tb_clock i_clock (.clk(clk), .rst_n(rst_n));

	io_subsystem i_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.leds    (leds),
		.i2s_sck (i2s_sck),
		.i2s_ws  (i2s_ws),
		.i2s_sd  (i2s_sd)
	);

	task automatic log_mismatch(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("Test %s: ok", name);
			tests_passed++;
		end else begin
			$display("Test %s: %0d errors", name, errors - errs_before);
			tests_failed++;
		end
	endtask

	task automatic bus_write_nowait(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		@(negedge clk);
		bus_req.valid = 1'b1;
		bus_req.wstrb = strb;
		bus_req.addr  = addr;
		bus_req.wdata = data;
	endtask

	// Ready is one cycle long, valid held through it and dropped a cycle later
	task automatic finish_access(output logic [31:0] rdata);
		do begin
			@(negedge clk);
		end while (!bus_rsp.ready);
		rdata = bus_rsp.rdata;
		@(negedge clk);
		bus_req = '0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] rsp_data;
		bus_write_nowait(addr, data, strb);
		finish_access(rsp_data);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
		bus_write_nowait(addr, 32'h0, 4'h0);
		finish_access(rdata);
	endtask

	// Left word while ws low, MSB first, sampled on rising sck
	task automatic capture_frames(input int n, input bit from_idle);
		logic [31:0] word;
		int f;
		int b;
		if (!from_idle) @(negedge i2s_ws);
		for (f = 0; f < n; f++) begin
			word = '0;
			for (b = 0; b < 32; b++) begin
				@(posedge i2s_sck);
				if (i2s_ws != (b >= 16)) log_mismatch($sformatf("ws wrong at bit %0d", b));
				word = {word[30:0], i2s_sd};
			end
			frames_q.push_back(word);
		end
	endtask

	// Sample holds right on top, the wire carries left first
	task automatic compare_frames();
		logic [31:0] expect_word;
		int i;
		for (i = 0; i < sample_q.size(); i++) begin
			expect_word = {sample_q[i][15:0], sample_q[i][31:16]};
			if (frames_q[i] != expect_word) begin
				log_mismatch($sformatf("frame %0d got %h expected %h", i, frames_q[i],
					expect_word));
			end
		end
	endtask

	task automatic test_after_reset();
		int errs;
		logic [31:0] rnd;
		logic [31:0] rdata;
		errs = errors;
		if (leds != 8'h00) log_mismatch($sformatf("leds %h after reset", leds));
		if (bus_rsp.ready) log_mismatch("ready high after reset");
		repeat (20) begin
			@(negedge clk);
			if (i2s_sck || i2s_ws || i2s_sd) log_mismatch("I2S line high while idle");
		end
		rnd = $random(seed);
		led_expect = rnd[7:0];
		bus_write(GPIO_ADDR, rnd, 4'h1);
		if (leds != led_expect) log_mismatch($sformatf("leds %h expected %h", leds, led_expect));
		bus_read(GPIO_ADDR, rdata);
		if (rdata != {24'h0, led_expect}) log_mismatch($sformatf("GPIO read %h", rdata));
		report_test("after reset", errs);
	endtask

	task automatic test_byte_lane();
		int errs;
		logic [31:0] rdata;
		errs = errors;
		// Lanes 1 to 3 only, LED byte must hold
		bus_write(GPIO_ADDR, {24'hffffff, ~led_expect}, 4'he);
		if (leds != led_expect) log_mismatch($sformatf("leds %h changed", leds));
		bus_read(UNMAPPED_ADDR, rdata);
		if (rdata != 32'h0) log_mismatch($sformatf("unmapped read %h", rdata));
		report_test("byte lane", errs);
	endtask

	task automatic test_streaming();
		int errs;
		int i;
		logic [31:0] rnd;
		logic [31:0] rdata;
		errs = errors;
		sample_q.delete();
		frames_q.delete();
		for (i = 0; i < 3; i++) begin
			rnd = $random(seed);
			sample_q.push_back(rnd);
			bus_write(AUDIO_SAMPLE, rnd, 4'hf);
		end
		bus_read(AUDIO_STATUS, rdata);
		if (rdata != 32'h3) log_mismatch($sformatf("STATUS %h expected 3", rdata));
		fork
			bus_write(AUDIO_CTRL, 32'h1, 4'hf);
			capture_frames(3, 1'b1);
		join
		compare_frames();
		report_test("streaming", errs);
	endtask

	task automatic test_underrun();
		int errs;
		logic [31:0] rdata;
		errs = errors;
		sample_q.delete();
		frames_q.delete();
		sample_q.push_back(32'h0);
		sample_q.push_back(32'h0);
		// Stream still running, empty FIFO sends silence
		capture_frames(2, 1'b0);
		compare_frames();
		bus_read(AUDIO_STATUS, rdata);
		if (rdata != 32'h100) log_mismatch($sformatf("STATUS %h expected 100", rdata));
		bus_write(AUDIO_CTRL, 32'h0, 4'hf);
		repeat (2 * FRAME_CLKS) @(negedge clk);
		if (i2s_sck || i2s_ws || i2s_sd) log_mismatch("I2S still active after disable");
		bus_write(AUDIO_STATUS, 32'h100, 4'hf);
		bus_read(AUDIO_STATUS, rdata);
		if (rdata != 32'h0) log_mismatch($sformatf("STATUS %h after clear", rdata));
		report_test("underrun", errs);
	endtask

	task automatic test_back_pressure();
		int errs;
		int i;
		logic [31:0] rnd;
		logic [31:0] rdata;
		errs = errors;
		sample_q.delete();
		frames_q.delete();
		for (i = 0; i < 5; i++) begin
			rnd = $random(seed);
			sample_q.push_back(rnd);
		end
		for (i = 0; i < 4; i++) begin
			bus_write(AUDIO_SAMPLE, sample_q[i], 4'hf);
		end
		bus_read(AUDIO_STATUS, rdata);
		if (rdata != 32'h4) log_mismatch($sformatf("STATUS %h expected 4", rdata));
		bus_write_nowait(AUDIO_SAMPLE, sample_q[4], 4'hf);
		repeat (200) begin
			@(negedge clk);
			if (bus_rsp.ready) log_mismatch("ready on write into full FIFO");
		end
		// Withdraw so the enable write can use the bus
		bus_req = '0;
		fork
			begin
				bus_write(AUDIO_CTRL, 32'h1, 4'hf);
				bus_write(AUDIO_SAMPLE, sample_q[4], 4'hf);
			end
			capture_frames(5, 1'b1);
		join
		compare_frames();
		report_test("back-pressure", errs);
	endtask

	initial begin
		#WATCHDOG_TIME;
		$display("Timeout: a test never finished, run stopped");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		bus_req      = '0;
		seed         = 12;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		led_expect   = 8'h00;
		@(posedge rst_n);
		test_after_reset();
		test_byte_lane();
		test_streaming();
		test_underrun();
		test_back_pressure();
		$display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Testbench clock source, period 40 time units, rst_n low for two cycles then released on a falling edge
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = !clk;
	end

	// Release away from the active edge
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/io_subsystem.sv
// Iomem peripheral side, one master, GPIO at 0x0300_0xxx and audio at 0x0300_6xxx
`default_nettype none

module io_subsystem import iomem_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  iomem_req_t bus_req,
	output iomem_rsp_t bus_rsp,
	output wire [7:0]  leds,
	output wire        i2s_sck,
	output wire        i2s_ws,
	output wire        i2s_sd
);

	// Per-target request and response
	iomem_req_t gpio_req;
	iomem_rsp_t gpio_rsp;
	iomem_req_t audio_req;
	iomem_rsp_t audio_rsp;

	iomem_decode i_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_req   (bus_req),
		.bus_rsp   (bus_rsp),
		.gpio_req  (gpio_req),
		.gpio_rsp  (gpio_rsp),
		.audio_req (audio_req),
		.audio_rsp (audio_rsp)
	);

	// LED register
	gpio_port i_gpio (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (gpio_req),
		.rsp   (gpio_rsp),
		.leds  (leds)
	);

	// Sample FIFO and I2S output
	audio_engine i_audio (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (audio_req),
		.rsp     (audio_rsp),
		.i2s_sck (i2s_sck),
		.i2s_ws  (i2s_ws),
		.i2s_sd  (i2s_sd)
	);

endmodule

`default_nettype wire

// File: rtl/audio_engine.sv
// Audio regs decode addr[3:2] only; any nonzero wstrb is a full write, sample writes stall while FIFO full
`default_nettype none

module audio_engine import iomem_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  iomem_req_t req,
	output iomem_rsp_t rsp,
	output wire        i2s_sck,
	output wire        i2s_ws,
	output wire        i2s_sd
);

	audio_reg_e reg_sel;
	logic is_write;
	logic access;
	logic done;
	logic ready_q;
	logic enable;
	logic underrun_flag;
	logic underrun;
	logic push;
	logic sample_pop;
	logic fifo_full;
	logic fifo_empty;
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_LVL_W-1:0] level;
	logic [31:0] read_val;
	stereo_sample_t fifo_mem [SAMPLE_FIFO_DEPTH];
	stereo_sample_t head_sample;

	assign reg_sel  = audio_reg_e'(req.addr[3:2]);
	assign is_write = |req.wstrb;
	assign access   = req.valid && !ready_q;

	// Sample writes wait for a free slot, everything else completes now
	assign push = access && is_write && (reg_sel == AREG_SAMPLE) && !fifo_full;
	assign done = access && !(is_write && (reg_sel == AREG_SAMPLE) && fifo_full);

	assign fifo_full   = (level == FIFO_LVL_W'(SAMPLE_FIFO_DEPTH));
	assign fifo_empty  = (level == '0);
	assign head_sample = fifo_mem[rd_ptr];

	// Sample storage
	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= stereo_sample_t'(req.wdata);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q       <= 1'b0;
			enable        <= 1'b0;
			underrun_flag <= 1'b0;
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			level         <= '0;
		end else begin
			ready_q <= done;
			if (done && is_write && (reg_sel == AREG_CTRL)) begin
				enable <= req.wdata[CTRL_ENABLE_BIT];
			end
			// Sticky, new underrun beats a clear
			if (underrun) begin
				underrun_flag <= 1'b1;
			end else if (done && is_write && (reg_sel == AREG_STATUS) &&
					req.wdata[STAT_UNDERRUN_BIT]) begin
				underrun_flag <= 1'b0;
			end
			// Pointers wrap on their own, depth is a power of two
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (sample_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !sample_pop) begin
				level <= level + 1'b1;
			end else if (sample_pop && !push) begin
				level <= level - 1'b1;
			end
		end
	end

	// Read mux, address still held in the ready cycle
	always_comb begin
		read_val = 32'h00000000;
		case (reg_sel)
			AREG_CTRL: read_val[CTRL_ENABLE_BIT] = enable;
			AREG_STATUS: begin
				read_val[FIFO_LVL_W-1:0]   = level;
				read_val[STAT_UNDERRUN_BIT] = underrun_flag;
			end
			AREG_SAMPLE, AREG_RSVD: read_val = 32'h00000000;
			default: read_val = 32'h00000000;
		endcase
	end

	assign rsp.ready = ready_q;
	assign rsp.rdata = ready_q ? read_val : 32'h00000000;

	i2s_tx i_i2s_tx (
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.head_sample (head_sample),
		.fifo_empty  (fifo_empty),
		.sample_pop  (sample_pop),
		.underrun    (underrun),
		.i2s_sck     (i2s_sck),
		.i2s_ws      (i2s_ws),
		.i2s_sd      (i2s_sd)
	);

	// Overflow check, level counter never passes the depth
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		level <= FIFO_LVL_W'(SAMPLE_FIFO_DEPTH)
	) else $error("audio_engine: FIFO level above depth");

	// Serializer must respect the empty flag
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		sample_pop |-> (level != '0)
	) else $error("audio_engine: pop from empty FIFO");

endmodule

`default_nettype wire

// File: rtl/i2s_tx.sv
// I2S master, 4 clk per bit, 32-bit frame, ws switches with the first bit of each word (no one-bit lag)
`default_nettype none

module i2s_tx import iomem_pkg::*; (
	input  wire            clk,
	input  wire            rst_n,
	input  wire            enable,
	input  stereo_sample_t head_sample,
	input  wire            fifo_empty,
	output wire            sample_pop,
	output wire            underrun,
	output wire            i2s_sck,
	output wire            i2s_ws,
	output wire            i2s_sd
);

	i2s_state_e state;
	logic [SCK_DIV_W-1:0] div;
	logic [FRAME_BIT_W-1:0] bit_cnt;
	logic [FRAME_BITS-1:0] shreg;
	logic sck_q;
	logic half_tick;
	logic fall_tick;
	logic last_bit;
	logic frame_start;

	// End of each half bit-clock
	assign half_tick = (state == I2S_RUN) && (div == SCK_DIV_W'(SCK_HALF - 1));
	// sck about to drop, data moves here
	assign fall_tick = half_tick && sck_q;
	assign last_bit  = (bit_cnt == FRAME_BIT_W'(FRAME_BITS - 1));

	// New frame from idle, or back to back at the boundary
	assign frame_start = enable && ((state == I2S_IDLE) || (fall_tick && last_bit));

	// Head of FIFO taken in the same cycle
	assign sample_pop = frame_start && !fifo_empty;
	assign underrun   = frame_start && fifo_empty;

	assign i2s_sck = sck_q;
	// Upper half of the frame is the right word
	assign i2s_ws = bit_cnt[FRAME_BIT_W-1];
	assign i2s_sd = shreg[FRAME_BITS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= I2S_IDLE;
			div     <= '0;
			bit_cnt <= '0;
			shreg   <= '0;
			sck_q   <= 1'b0;
		end else if (frame_start) begin
			state   <= I2S_RUN;
			div     <= '0;
			bit_cnt <= '0;
			sck_q   <= 1'b0;
			// Left word first, silence on underrun
			shreg   <= fifo_empty ? '0 : {head_sample.left, head_sample.right};
		end else if (state == I2S_RUN) begin
			if (half_tick) begin
				div   <= '0;
				sck_q <= !sck_q;
				if (sck_q) begin
					if (last_bit) begin
						// Frame done and enable low
						state   <= I2S_IDLE;
						bit_cnt <= '0;
						shreg   <= '0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						shreg   <= shreg << 1;
					end
				end
			end else begin
				div <= div + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/gpio_port.sv
// Eight LED bits at any offset in the GPIO block; only byte lane 0 writes, every access reads leds
`default_nettype none

module gpio_port import iomem_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  iomem_req_t req,
	output iomem_rsp_t rsp,
	output logic [7:0] leds
);

	logic ready_q;
	logic access;

	// First cycle of a request, ready still low
	assign access = req.valid && !ready_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= 1'b0;
			leds    <= 8'h00;
		end else begin
			// Fixed one-cycle latency
			ready_q <= access;
			// Low byte lane only, upper lanes ignored
			if (access && req.wstrb[0]) begin
				leds <= req.wdata[7:0];
			end
		end
	end

	// Readback shows the value after any write
	assign rsp.ready = ready_q;
	assign rsp.rdata = ready_q ? {24'h000000, leds} : 32'h00000000;

endmodule

`default_nettype wire

// File: rtl/iomem_decode.sv
// Decodes addr[31:24] and addr[15:12] only; other address bits alias, unmapped accesses read zero
`default_nettype none

module iomem_decode import iomem_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  iomem_req_t bus_req,
	output iomem_rsp_t bus_rsp,
	output iomem_req_t gpio_req,
	input  iomem_rsp_t gpio_rsp,
	output iomem_req_t audio_req,
	input  iomem_rsp_t audio_rsp
);

	logic page_hit;
	logic sel_gpio;
	logic sel_audio;
	logic unmapped;
	logic unmap_ready;

	// Page compare shared by both targets
	assign page_hit  = (bus_req.addr[31:24] == IOMEM_PAGE);
	assign sel_gpio  = bus_req.valid && page_hit && (bus_req.addr[15:12] == GPIO_BLOCK);
	assign sel_audio = bus_req.valid && page_hit && (bus_req.addr[15:12] == AUDIO_BLOCK);

	// Anything else that is valid gets answered here
	assign unmapped = bus_req.valid && !sel_gpio && !sel_audio;

	// Fan out request, valid gated per target
	always_comb begin
		gpio_req        = bus_req;
		gpio_req.valid  = sel_gpio;
		audio_req       = bus_req;
		audio_req.valid = sel_audio;
	end

	// Dummy responder for holes in the map
	// Never two readies back to back
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unmap_ready <= 1'b0;
		end else begin
			unmap_ready <= unmapped && !unmap_ready;
		end
	end

	// Idle targets drive zeros, so a plain OR merges
	assign bus_rsp.ready = gpio_rsp.ready | audio_rsp.ready | unmap_ready;
	assign bus_rsp.rdata = gpio_rsp.rdata | audio_rsp.rdata;

	// Targets must not answer an idle bus
	a_ready_needs_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus_rsp.ready |-> bus_req.valid
	) else $error("iomem_decode: ready without valid");

	// Two responders at once would corrupt rdata
	a_one_responder: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0({gpio_rsp.ready, audio_rsp.ready, unmap_ready})
	) else $error("iomem_decode: overlapping responses");

endmodule

`default_nettype wire

// File: rtl/iomem_pkg.sv
// Shared iomem types and audio map; iomem page 0x03, one master, level field holds 0..4 only
`default_nettype none

package iomem_pkg;

	// Master request, held stable until ready
	typedef struct packed {
		logic        valid;
		logic [3:0]  wstrb;
		logic [31:0] addr;
		logic [31:0] wdata;
	} iomem_req_t;

	// Target response, rdata must be zero while ready is low
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} iomem_rsp_t;

	// One stereo pair, right channel on top
	typedef struct packed {
		logic [15:0] right;
		logic [15:0] left;
	} stereo_sample_t;

	// Address map
	localparam logic [7:0] IOMEM_PAGE  = 8'h03;
	localparam logic [3:0] GPIO_BLOCK  = 4'h0;
	localparam logic [3:0] AUDIO_BLOCK = 4'h6;

	// Audio register word offsets, addr[3:2]
	typedef enum logic [1:0] {
		AREG_CTRL   = 2'd0,
		AREG_SAMPLE = 2'd1,
		AREG_STATUS = 2'd2,
		AREG_RSVD   = 2'd3
	} audio_reg_e;

	localparam int CTRL_ENABLE_BIT   = 0;
	localparam int STAT_UNDERRUN_BIT = 8;

	// Sample FIFO
	localparam int SAMPLE_FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W        = $clog2(SAMPLE_FIFO_DEPTH);
	localparam int FIFO_LVL_W        = $clog2(SAMPLE_FIFO_DEPTH + 1);

	// I2S timing, clk cycles per half bit-clock and bits per frame
	typedef enum logic {
		I2S_IDLE = 1'b0,
		I2S_RUN  = 1'b1
	} i2s_state_e;

	localparam int SCK_HALF    = 2;
	localparam int SCK_DIV_W   = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
	localparam int FRAME_BITS  = 32;
	localparam int FRAME_BIT_W = $clog2(FRAME_BITS);

endpackage

`default_nettype wire
